// ==== mdu_op_pkg.sv ====
package mdu_op_pkg;

  // Bit 1 set means operand B is unsigned, MULHU also clears A's sign
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'b00,
    MUL_OP_MULH   = 2'b01,
    MUL_OP_MULHSU = 2'b10,
    MUL_OP_MULHU  = 2'b11
  } mul_op_e;

  // Bit 0 is unsigned, bit 1 selects the remainder
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

endpackage

// ==== mdu_word_pkg.sv ====
package mdu_word_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 64;

  // Word ops sign-extend their result from bit WLEN-1
  localparam int unsigned WLEN = 32;

endpackage

// ==== mdu_mul.sv ====
module mdu_mul (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic [mdu_word_pkg::XLEN-1:0] operand_a_i,
  input  logic [mdu_word_pkg::XLEN-1:0] operand_b_i,
  input  mdu_op_pkg::mul_op_e           req_op_i,
  input  logic                          req_word_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,

  output logic                          resp_valid_o,
  output logic [mdu_word_pkg::XLEN-1:0] resp_value_o
);

  import mdu_op_pkg::*;
  import mdu_word_pkg::*;

  // One 17x17 MAC walks the 4x4 slice grid column by column.
  // Each entry is {a_idx, b_idx}; columns end at steps 0, 2, 5, 9, 12, 14, 15
  localparam logic [3:0] Schedule [16] = '{
    4'h0, 4'h4, 4'h1, 4'h2, 4'h5, 4'h8, 4'hC, 4'h9,
    4'h6, 4'h3, 4'h7, 4'hA, 4'hD, 4'hE, 4'hB, 4'hF
  };

  typedef enum logic {
    StIdle,
    StBusy
  } state_e;

  state_e state_q, state_d;
  logic [3:0] step_q, step_d;

  // Operands with one extra sign bit on top
  logic [XLEN:0] a_q, a_d;
  logic [XLEN:0] b_q, b_d;
  logic low_q, low_d;
  logic word_q, word_d;

  logic [34:0] accum_q, accum_d;
  logic [1:0]  a_idx;
  logic [1:0]  b_idx;
  logic [16:0] mac_a;
  logic [16:0] mac_b;
  logic [34:0] mac_prod;
  // Column sum shifted down for the next column
  logic [34:0] carry;

  logic            done;
  logic [XLEN-1:0] value_d;

  assign req_ready_o = state_q == StIdle;

  assign a_idx = Schedule[step_q][3:2];
  assign b_idx = Schedule[step_q][1:0];

  // Lower slices are zero-extended, the top slice carries the sign
  always_comb begin
    case (a_idx)
      2'd0: mac_a = {1'b0, a_q[15:0]};
      2'd1: mac_a = {1'b0, a_q[31:16]};
      2'd2: mac_a = {1'b0, a_q[47:32]};
      default: mac_a = a_q[64:48];
    endcase
    case (b_idx)
      2'd0: mac_b = {1'b0, b_q[15:0]};
      2'd1: mac_b = {1'b0, b_q[31:16]};
      2'd2: mac_b = {1'b0, b_q[47:32]};
      default: mac_b = b_q[64:48];
    endcase
  end

  assign mac_prod = $signed(accum_q) + $signed(mac_a) * $signed(mac_b);
  assign carry    = {{16{mac_prod[34]}}, mac_prod[34:16]};

  always_comb begin
    state_d = state_q;
    step_d  = step_q;
    a_d     = a_q;
    b_d     = b_q;
    low_d   = low_q;
    word_d  = word_q;
    accum_d = accum_q;
    value_d = resp_value_o;
    done    = 1'b0;

    unique case (state_q)
      StIdle: begin
        if (req_valid_i) begin
          a_d     = {(req_op_i != MUL_OP_MULHU) & operand_a_i[XLEN-1], operand_a_i};
          b_d     = {~req_op_i[1] & operand_b_i[XLEN-1], operand_b_i};
          low_d   = req_op_i == MUL_OP_MUL;
          word_d  = req_word_i;
          accum_d = '0;
          step_d  = 4'd0;
          state_d = StBusy;
        end
      end
      StBusy: begin
        accum_d = mac_prod;
        step_d  = step_q + 4'd1;
        case (step_q)
          4'd0: begin
            value_d[15:0] = mac_prod[15:0];
            accum_d       = carry;
          end
          4'd2: begin
            if (word_q) begin
              value_d[XLEN-1:16] = {{(XLEN-WLEN){mac_prod[15]}}, mac_prod[15:0]};
              done               = 1'b1;
            end else begin
              value_d[31:16] = mac_prod[15:0];
              accum_d        = carry;
            end
          end
          4'd5: begin
            value_d[47:32] = mac_prod[15:0];
            accum_d        = carry;
          end
          4'd9: begin
            value_d[63:48] = mac_prod[15:0];
            if (low_q) begin
              done = 1'b1;
            end else begin
              accum_d = carry;
            end
          end
          // High half from here on, written over the low result
          4'd12: begin
            value_d[15:0] = mac_prod[15:0];
            accum_d       = carry;
          end
          4'd14: begin
            value_d[31:16] = mac_prod[15:0];
            accum_d        = carry;
          end
          4'd15: begin
            value_d[63:32] = mac_prod[31:0];
            done           = 1'b1;
          end
          default: begin
          end
        endcase
        if (done) begin
          state_d = StIdle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= StIdle;
      step_q       <= 4'd0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      step_q       <= step_d;
      resp_valid_o <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    a_q          <= a_d;
    b_q          <= b_d;
    low_q        <= low_d;
    word_q       <= word_d;
    accum_q      <= accum_d;
    resp_value_o <= value_d;
  end

endmodule

// ==== mdu_div.sv ====
module mdu_div #(
  parameter int unsigned DivBitsPerCycle = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic [mdu_word_pkg::XLEN-1:0] operand_a_i,
  input  logic [mdu_word_pkg::XLEN-1:0] operand_b_i,
  input  mdu_op_pkg::div_op_e           req_op_i,
  input  logic                          req_word_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,

  output logic                          resp_valid_o,
  output logic [mdu_word_pkg::XLEN-1:0] resp_value_o
);

  import mdu_op_pkg::*;
  import mdu_word_pkg::*;

  localparam int unsigned FullSteps = XLEN / DivBitsPerCycle;
  localparam int unsigned WordSteps = WLEN / DivBitsPerCycle;
  localparam int unsigned CntW      = $clog2(FullSteps + 1);

  typedef enum logic [1:0] {
    StIdle,
    StSetup,
    StIter,
    StFinish
  } state_e;

  state_e state_q, state_d;
  logic [CntW-1:0] cnt_q, cnt_d;

  // Request as accepted, held until the result leaves
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;
  div_op_e         op_q;
  logic            word_q;

  logic [XLEN-1:0] divisor_q;
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] quo_q;
  logic            quo_neg_q;
  logic            rem_neg_q;
  logic            zero_q;

  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  logic [XLEN:0]   trial;
  logic [XLEN-1:0] rem_step;
  logic [XLEN-1:0] quo_step;

  logic [XLEN-1:0] quo_res;
  logic [XLEN-1:0] rem_res;
  logic [XLEN-1:0] res;

  assign req_ready_o  = state_q == StIdle;
  assign resp_valid_o = state_q == StFinish;

  assign is_signed = ~op_q[0];

  // Word ops only see the low WLEN bits
  always_comb begin
    if (word_q) begin
      a_ext = {{(XLEN-WLEN){is_signed & a_q[WLEN-1]}}, a_q[WLEN-1:0]};
      b_ext = {{(XLEN-WLEN){is_signed & b_q[WLEN-1]}}, b_q[WLEN-1:0]};
    end else begin
      a_ext = a_q;
      b_ext = b_q;
    end
    a_neg = is_signed & a_ext[XLEN-1];
    b_neg = is_signed & b_ext[XLEN-1];
    a_mag = a_neg ? -a_ext : a_ext;
    b_mag = b_neg ? -b_ext : b_ext;
  end

  // Restoring steps shift the dividend bits out of the top of quo_q
  always_comb begin
    rem_step = rem_q;
    quo_step = quo_q;
    for (int i = 0; i < DivBitsPerCycle; i++) begin
      trial    = {rem_step, quo_step[XLEN-1]};
      quo_step = {quo_step[XLEN-2:0], 1'b0};
      if (trial >= {1'b0, divisor_q}) begin
        trial       = trial - {1'b0, divisor_q};
        quo_step[0] = 1'b1;
      end
      rem_step = trial[XLEN-1:0];
    end
  end

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      StIdle: begin
        if (req_valid_i) begin
          state_d = StSetup;
        end
      end
      StSetup: begin
        cnt_d   = word_q ? CntW'(WordSteps) : CntW'(FullSteps);
        state_d = StIter;
      end
      StIter: begin
        cnt_d = cnt_q - 1'b1;
        if (cnt_q == CntW'(1)) begin
          state_d = StFinish;
        end
      end
      StFinish: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    unique case (state_q)
      StIdle: begin
        if (req_valid_i) begin
          a_q    <= operand_a_i;
          b_q    <= operand_b_i;
          op_q   <= req_op_i;
          word_q <= req_word_i;
        end
      end
      StSetup: begin
        divisor_q <= b_mag;
        rem_q     <= '0;
        // Left-align a word dividend so both widths shift from the top
        quo_q     <= word_q ? {a_mag[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : a_mag;
        quo_neg_q <= a_neg ^ b_neg;
        rem_neg_q <= a_neg;
        zero_q    <= b_ext == '0;
      end
      StIter: begin
        rem_q <= rem_step;
        quo_q <= quo_step;
      end
      StFinish: begin
      end
    endcase
  end

  // Most negative over minus one wraps the magnitude 2^(n-1) back to the dividend
  always_comb begin
    quo_res = quo_neg_q ? -quo_q : quo_q;
    rem_res = rem_neg_q ? -rem_q : rem_q;
    if (zero_q) begin
      quo_res = '1;
      rem_res = a_q;
    end
    res = op_q[1] ? rem_res : quo_res;
  end

  assign resp_value_o = word_q ? {{(XLEN-WLEN){res[WLEN-1]}}, res[WLEN-1:0]} : res;

endmodule

// ==== mdu_dispatch.sv ====
module mdu_dispatch (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          req_div_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,

  output logic                          mul_valid_o,
  input  logic                          mul_ready_i,
  output logic                          div_valid_o,
  input  logic                          div_ready_i,

  input  logic                          mul_resp_valid_i,
  input  logic [mdu_word_pkg::XLEN-1:0] mul_resp_value_i,
  input  logic                          div_resp_valid_i,
  input  logic [mdu_word_pkg::XLEN-1:0] div_resp_value_i,

  output logic                          resp_valid_o,
  output logic [mdu_word_pkg::XLEN-1:0] resp_value_o
);

  logic busy_q;
  // High when the divider owns the operation in flight
  logic owner_div_q;
  logic accept;
  logic own_valid;

  assign req_ready_o = ~busy_q & mul_ready_i & div_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign mul_valid_o = accept & ~req_div_i;
  assign div_valid_o = accept & req_div_i;

  // Only the owner's response counts
  assign own_valid = busy_q & (owner_div_q ? div_resp_valid_i : mul_resp_valid_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      owner_div_q  <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        busy_q      <= 1'b1;
        owner_div_q <= req_div_i;
      end else if (own_valid) begin
        busy_q <= 1'b0;
      end
      resp_valid_o <= own_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (own_valid) begin
      resp_value_o <= owner_div_q ? div_resp_value_i : mul_resp_value_i;
    end
  end

endmodule

// ==== mdu_top.sv ====
module mdu_top #(
  parameter int unsigned DivBitsPerCycle = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic [mdu_word_pkg::XLEN-1:0] operand_a_i,
  input  logic [mdu_word_pkg::XLEN-1:0] operand_b_i,
  input  logic                          req_div_i,
  input  mdu_op_pkg::mul_op_e           req_mul_op_i,
  input  mdu_op_pkg::div_op_e           req_div_op_i,
  input  logic                          req_word_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,

  output logic                          resp_valid_o,
  output logic [mdu_word_pkg::XLEN-1:0] resp_value_o
);

  import mdu_word_pkg::*;

  logic            mul_valid;
  logic            mul_ready;
  logic            mul_resp_valid;
  logic [XLEN-1:0] mul_resp_value;

  logic            div_valid;
  logic            div_ready;
  logic            div_resp_valid;
  logic [XLEN-1:0] div_resp_value;

  mdu_dispatch i_dispatch (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_div_i        (req_div_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .mul_valid_o      (mul_valid),
    .mul_ready_i      (mul_ready),
    .div_valid_o      (div_valid),
    .div_ready_i      (div_ready),
    .mul_resp_valid_i (mul_resp_valid),
    .mul_resp_value_i (mul_resp_value),
    .div_resp_valid_i (div_resp_valid),
    .div_resp_value_i (div_resp_value),
    .resp_valid_o     (resp_valid_o),
    .resp_value_o     (resp_value_o)
  );

  // Operands fan out to both units, valid picks one
  mdu_mul i_mul (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (req_mul_op_i),
    .req_word_i   (req_word_i),
    .req_valid_i  (mul_valid),
    .req_ready_o  (mul_ready),
    .resp_valid_o (mul_resp_valid),
    .resp_value_o (mul_resp_value)
  );

  mdu_div #(
    .DivBitsPerCycle (DivBitsPerCycle)
  ) i_div (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (req_div_op_i),
    .req_word_i   (req_word_i),
    .req_valid_i  (div_valid),
    .req_ready_o  (div_ready),
    .resp_valid_o (div_resp_valid),
    .resp_value_o (div_resp_value)
  );

endmodule

// ==== mdu_sva.sv ====
module mdu_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic req_ready_i,
  input logic resp_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // No response may leave while in reset
  assert property (@(posedge clk_i) !rst_ni |-> !resp_valid_i)
    else $error("resp_valid_o high during reset");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> !resp_valid_i)
    else $error("resp_valid_o high for two cycles in a row");

  // Busy from the cycle after acceptance
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_ready_i) |=> !req_ready_i)
    else $error("req_ready_o still high after an accepted request");

  // Ready only comes back together with the response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_ready_i) |-> resp_valid_i)
    else $error("req_ready_o returned high without a response");

endmodule

bind mdu_top mdu_sva i_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (req_valid_i),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o)
);

// ==== tb_mdu.sv ====
module tb_mdu;
  timeunit 1ns;
  timeprecision 1ps;

  import mdu_op_pkg::*;
  import mdu_word_pkg::*;

  localparam int unsigned DivBits       = 2;
  localparam int unsigned NumReqs       = 600;
  localparam int unsigned TimeoutCycles = NumReqs * 40 + 100;
  localparam int unsigned Seed          = 5767;

  logic            clk_i;
  logic            rst_ni;
  logic [XLEN-1:0] operand_a_i;
  logic [XLEN-1:0] operand_b_i;
  logic            req_div_i;
  mul_op_e         req_mul_op_i;
  div_op_e         req_div_op_i;
  logic            req_word_i;
  logic            req_valid_i;
  logic            req_ready_o;
  logic            resp_valid_o;
  logic [XLEN-1:0] resp_value_o;

  // Accepted requests still waiting for their response
  logic [XLEN-1:0] exp_q[$];
  int unsigned     lat_q[$];
  int unsigned     start_q[$];
  string           name_q[$];

  int unsigned cycle_cnt;
  int unsigned accept_cnt;
  int unsigned resp_cnt;
  int unsigned div_bits;
  logic        busy;

  mdu_top #(
    .DivBitsPerCycle (DivBits)
  ) i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_div_i    (req_div_i),
    .req_mul_op_i (req_mul_op_i),
    .req_div_op_i (req_div_op_i),
    .req_word_i   (req_word_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Run stopped at cycle %0d", cycle_cnt);
  endtask

  function automatic string op_name(logic is_div, logic [1:0] op, logic word);
    string base;
    if (is_div) begin
      case (div_op_e'(op))
        DIV_OP_DIV:  base = "DIV";
        DIV_OP_DIVU: base = "DIVU";
        DIV_OP_REM:  base = "REM";
        default:     base = "REMU";
      endcase
    end else begin
      case (mul_op_e'(op))
        MUL_OP_MUL:    base = "MUL";
        MUL_OP_MULH:   base = "MULH";
        MUL_OP_MULHSU: base = "MULHSU";
        default:       base = "MULHU";
      endcase
    end
    return word ? {base, "W"} : base;
  endfunction

  // Full 128-bit product, then pick the slice the op asks for
  function automatic logic [XLEN-1:0] model_mul(logic [1:0] op, logic word,
                                                logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic         a_signed;
    logic         b_signed;
    logic [127:0] a_ext;
    logic [127:0] b_ext;
    logic [127:0] prod;
    a_signed = op != MUL_OP_MULHU;
    b_signed = (op == MUL_OP_MUL) || (op == MUL_OP_MULH);
    a_ext    = {{64{a_signed & a[63]}}, a};
    b_ext    = {{64{b_signed & b[63]}}, b};
    prod     = a_ext * b_ext;
    if (word) begin
      return {{32{prod[31]}}, prod[31:0]};
    end
    return (op == MUL_OP_MUL) ? prod[63:0] : prod[127:64];
  endfunction

  function automatic logic [XLEN-1:0] model_div(logic [1:0] op, logic word,
                                                logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic                is_signed;
    int                  n;
    logic signed [127:0] x;
    logic signed [127:0] y;
    logic signed [127:0] q;
    logic signed [127:0] r;
    logic [XLEN-1:0]     res;
    is_signed = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
    n         = word ? 32 : 64;
    if (word) begin
      x = {{96{is_signed & a[31]}}, a[31:0]};
      y = {{96{is_signed & b[31]}}, b[31:0]};
    end else begin
      x = {{64{is_signed & a[63]}}, a};
      y = {{64{is_signed & b[63]}}, b};
    end
    if (y == 0) begin
      q = '1;
      r = x;
    end else if (is_signed && y == -128'sd1 && x == -(128'sd1 <<< (n - 1))) begin
      q = x;
      r = '0;
    end else begin
      q = x / y;
      r = x % y;
    end
    res = (op == DIV_OP_REM || op == DIV_OP_REMU) ? r[63:0] : q[63:0];
    return word ? {{32{res[31]}}, res[31:0]} : res;
  endfunction

  function automatic int unsigned expected_latency(logic is_div, logic [1:0] op, logic word);
    if (is_div) begin
      return (word ? WLEN : XLEN) / div_bits + 3;
    end
    if (word) begin
      return 5;
    end
    return (op == MUL_OP_MUL) ? 12 : 18;
  endfunction

  // About one draw in eight comes from the corner set
  function automatic logic [XLEN-1:0] draw_operand(logic word);
    if ($urandom % 8 != 0) begin
      return {$urandom, $urandom};
    end
    case ($urandom % 4)
      0:       return '0;
      1:       return '1;
      2:       return word ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;
      default: return 64'd1;
    endcase
  endfunction

  task automatic drive_request(input logic valid);
    logic            is_div;
    logic            word;
    logic [1:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    is_div = 1'($urandom % 2);
    if (is_div) begin
      op   = 2'($urandom % 4);
      word = 1'($urandom % 2);
    end else begin
      // Only MUL has a word form
      word = ($urandom % 4) == 0;
      if (word) begin
        op = MUL_OP_MUL;
      end else begin
        op = 2'($urandom % 4);
      end
    end
    a = draw_operand(word);
    b = draw_operand(word);
    // Steer some divides onto zero divisor and signed overflow
    if (is_div && ($urandom % 8) == 0) begin
      if ($urandom % 2) begin
        b = '0;
      end else begin
        a = word ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;
        b = '1;
      end
    end
    req_valid_i  <= valid;
    req_div_i    <= is_div;
    req_word_i   <= word;
    req_mul_op_i <= mul_op_e'(op);
    req_div_op_i <= div_op_e'(op);
    operand_a_i  <= a;
    operand_b_i  <= b;
  endtask

  task automatic observe_edge();
    logic [XLEN-1:0] exp_val;
    int unsigned     lat;
    int unsigned     start;
    string           name;
    logic [1:0]      op;
    cycle_cnt++;
    assert (cycle_cnt < TimeoutCycles) else begin
      $display("Timeout: run not finished after %0d cycles", cycle_cnt);
      abort_run();
    end
    if (resp_valid_o) begin
      assert (exp_q.size() > 0) else begin
        $display("Response seen with no accepted request outstanding");
        abort_run();
      end
      exp_val = exp_q.pop_front();
      lat     = lat_q.pop_front();
      start   = start_q.pop_front();
      name    = name_q.pop_front();
      resp_cnt++;
      busy = 1'b0;
      assert (resp_value_o === exp_val) else begin
        $display("error %s: expected %h, actual %h", name, exp_val, resp_value_o);
        abort_run();
      end
      assert (cycle_cnt - start == lat) else begin
        $display("error %s latency: expected %0d, actual %0d", name, lat, cycle_cnt - start);
        abort_run();
      end
    end
    // A new request may be taken in the response cycle
    if (req_valid_i && req_ready_o) begin
      op = req_div_i ? 2'(req_div_op_i) : 2'(req_mul_op_i);
      exp_q.push_back(req_div_i ? model_div(op, req_word_i, operand_a_i, operand_b_i)
                                : model_mul(op, req_word_i, operand_a_i, operand_b_i));
      lat_q.push_back(expected_latency(req_div_i, op, req_word_i));
      start_q.push_back(cycle_cnt);
      name_q.push_back(op_name(req_div_i, op, req_word_i));
      accept_cnt++;
      busy = 1'b1;
    end
  endtask

  initial begin
    rst_ni       = 1'b0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    req_div_i    = 1'b0;
    req_mul_op_i = MUL_OP_MUL;
    req_div_op_i = DIV_OP_DIV;
    req_word_i   = 1'b0;
    req_valid_i  = 1'b0;
    cycle_cnt    = 0;
    accept_cnt   = 0;
    resp_cnt     = 0;
    busy         = 1'b0;
    div_bits     = i_dut.DivBitsPerCycle;
    void'($urandom(Seed));
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    while (resp_cnt < NumReqs) begin
      @(posedge clk_i);
      observe_edge();
      if (accept_cnt >= NumReqs) begin
        req_valid_i <= 1'b0;
      end else if (!busy) begin
        drive_request(1'b1);
      end else begin
        // Ignored by the DUT while ready is low
        drive_request(($urandom % 2) == 0);
      end
    end

    // Idle tail to catch a stray response
    repeat (40) begin
      @(posedge clk_i);
      observe_edge();
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
mdu_op_pkg.sv
mdu_word_pkg.sv
mdu_mul.sv
mdu_div.sv
mdu_dispatch.sv
mdu_top.sv
mdu_sva.sv
tb_mdu.sv

// ==== Bender.yml ====
package:
  name: mdu

sources:
  - mdu_op_pkg.sv
  - mdu_word_pkg.sv
  - mdu_mul.sv
  - mdu_div.sv
  - mdu_dispatch.sv
  - mdu_top.sv
  - target: test
    files:
      - mdu_sva.sv
      - tb_mdu.sv
